// File: Makefile
VERILATOR ?= verilator
TOP       ?= portalTb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
FAIL_MSG  ?= tests failed

SRCS    := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	@$(SIM_BIN) $(RUN_ARGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
	  echo "Simulation FAILED, see $(LOG)"; exit 1; \
	else \
	  echo "Simulation PASSED"; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: sim/portalProperties.sv
`timescale 1ns/1ps

module portalProperties (
  input logic                            CLK,
  input logic                            RST_N,
  input logic                            wbCyc,
  input logic                            wbStb,
  input logic                            wbWe,
  input portalPkg::portalAddrT           wbAdr,
  input logic [portalPkg::dataWidth-1:0] wbDatW,
  input logic                            wbAck,
  input logic                            irq
);
  import portalPkg::*;

  int   failCount = 0;
  logic ackSeen;
  logic onCtrlPage;
  logic enableWrite;
  logic pushDone;
  logic popDone;
  logic enModel;
  logic enNext;
  int   depthModel;
  int   depthNext;

  // --------------------------------------------------------------------
  // Enable and queue state as seen from the bus.
  // --------------------------------------------------------------------
  // An ack in this cycle means its side effect landed on the previous edge.
  assign ackSeen     = wbAck && wbCyc && wbStb;
  assign onCtrlPage  = (wbAdr.ctrlView.region == '0);
  assign enableWrite = ackSeen && wbWe && onCtrlPage && !wbAdr.ctrlView.portalSel &&
                       (wbAdr.ctrlView.regOffset == offIntrEnable);
  assign pushDone    = ackSeen && wbWe && !onCtrlPage && wbAdr.methodView.portalSel &&
                       (wbAdr.methodView.wordOffset == offMethodData);
  assign popDone     = ackSeen && !wbWe && !onCtrlPage && !wbAdr.methodView.portalSel &&
                       (wbAdr.methodView.wordOffset == offMethodData);

  assign enNext    = enableWrite ? wbDatW[0] : enModel;
  assign depthNext = depthModel + int'(pushDone) - int'(popDone);

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      enModel    <= 1'b0;
      depthModel <= 0;
    end else begin
      enModel    <= enNext;
      depthModel <= depthNext;
    end
  end

  // --------------------------------------------------------------------
  // Wishbone handshake.
  // --------------------------------------------------------------------
  ackInCycle: assert property (@(posedge CLK) disable iff (!RST_N)
      wbAck |-> wbCyc && wbStb)
    else begin
      failCount++;
      $error("wbAck high without an active cycle and strobe");
    end

  ackSingle: assert property (@(posedge CLK) disable iff (!RST_N)
      wbAck |=> !wbAck)
    else begin
      failCount++;
      $error("wbAck high for two cycles in a row");
    end

  // --------------------------------------------------------------------
  // Interrupt and reset.
  // --------------------------------------------------------------------
  irqQuiet: assert property (@(posedge CLK) disable iff (!RST_N)
      !(enNext && depthNext != 0) |-> !irq)
    else begin
      failCount++;
      $error("irq high with no enabled indication pending");
    end

  // Outputs settle one edge into reset.
  resetQuiet: assert property (@(posedge CLK)
      !RST_N |=> !wbAck && !irq)
    else begin
      failCount++;
      $error("wbAck or irq high during reset");
    end

endmodule

bind portalTop portalProperties props_i (
  .CLK    (CLK),
  .RST_N  (RST_N),
  .wbCyc  (wbCyc),
  .wbStb  (wbStb),
  .wbWe   (wbWe),
  .wbAdr  (wbAdr),
  .wbDatW (wbDatW),
  .wbAck  (wbAck),
  .irq    (irq)
);

// File: sim/portalTb.sv
`timescale 1ns/1ps

module portalTb;
  import portalPkg::*;

  localparam int clkPeriod    = 40;
  localparam int resetCycles  = 5;
  localparam int queueDepth   = fifoDepth;
  localparam int randomRounds = 4;
  localparam int stallCycles  = 8;
  // Upper bound on bus transfers over the whole run.
  localparam int numTransfers = 40 + randomRounds * 2 * queueDepth + 4 * queueDepth;
  localparam int cyclesPerTransfer = 4;
  localparam int timeoutNs = 2 * clkPeriod *
      (resetCycles + stallCycles + numTransfers * cyclesPerTransfer);
  localparam logic [31:0] lfsrSeed = 32'd93388;
  localparam logic [31:0] lfsrTaps = 32'h80200003;

  logic                 CLK;
  logic                 RST_N;
  logic                 wbCyc;
  logic                 wbStb;
  logic                 wbWe;
  portalAddrT           wbAdr;
  logic [dataWidth-1:0] wbDatW;
  logic [dataWidth-1:0] wbDatR;
  logic                 wbAck;
  logic                 irq;

  logic [31:0]          lfsrState = lfsrSeed;
  int                   errorCount = 0;
  logic [dataWidth-1:0] expectQ [$];

  portalTop #(
    .fifoDepth (queueDepth)
  ) dut_i (
    .CLK    (CLK),
    .RST_N  (RST_N),
    .wbCyc  (wbCyc),
    .wbStb  (wbStb),
    .wbWe   (wbWe),
    .wbAdr  (wbAdr),
    .wbDatW (wbDatW),
    .wbDatR (wbDatR),
    .wbAck  (wbAck),
    .irq    (irq)
  );

  initial begin
    CLK = 1'b0;
    forever #(clkPeriod / 2) CLK = ~CLK;
  end

  initial begin
    #(timeoutNs);
    $display("Watchdog expired after %0d ns, the bus stopped responding", timeoutNs);
    $display("tests failed");
    $finish;
  end

  // --------------------------------------------------------------------
  // Stimulus helpers.
  // --------------------------------------------------------------------
  // Galois LFSR, stepped once per bit taken.
  function automatic logic [31:0] takeBits(input int n);
    logic [31:0] result;
    result = '0;
    for (int i = 0; i < n; i++) begin
      result = {result[30:0], lfsrState[0]};
      lfsrState = lfsrState[0] ? ((lfsrState >> 1) ^ lfsrTaps) : (lfsrState >> 1);
    end
    return result;
  endfunction

  function automatic portalAddrT ctrlAddr(input logic sel, input logic [4:0] offset);
    portalAddrT a;
    a = '0;
    a.ctrlView.portalSel = sel;
    a.ctrlView.regOffset = offset;
    return a;
  endfunction

  // Nonzero pad keeps method 0 off the control page.
  function automatic portalAddrT methodAddr(input logic sel, input methodT m,
                                            input logic [4:0] offset);
    portalAddrT a;
    a = '0;
    a.methodView.portalSel  = sel;
    a.methodView.pad        = 5'd1;
    a.methodView.methodSel  = m;
    a.methodView.wordOffset = offset;
    return a;
  endfunction

  task automatic busAccess(input logic write, input portalAddrT addr,
                           input logic [dataWidth-1:0] data,
                           output logic [dataWidth-1:0] rdata);
    @(negedge CLK);
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = write;
    wbAdr  = addr;
    wbDatW = data;
    @(negedge CLK);
    while (!wbAck) begin
      @(negedge CLK);
    end
    rdata = wbDatR;
    // Strobe stays up across the edge that samples the ack.
    @(negedge CLK);
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  task automatic busWrite(input portalAddrT addr, input logic [dataWidth-1:0] data);
    logic [dataWidth-1:0] unused;
    busAccess(1'b1, addr, data, unused);
  endtask

  task automatic checkRead(input portalAddrT addr, input logic [dataWidth-1:0] expected,
                           input string what);
    logic [dataWidth-1:0] got;
    busAccess(1'b0, addr, '0, got);
    assert (got === expected) else begin
      $display("[ERROR] %0d ns: %s read 0x%08h, expected 0x%08h", $time, what, got, expected);
      errorCount++;
    end
  endtask

  task automatic checkIrq(input logic expected, input string what);
    assert (irq === expected) else begin
      $display("[ERROR] %0d ns: %s, irq is %0b", $time, what, irq);
      errorCount++;
    end
  endtask

  task automatic pushWord(input methodT m, input logic [dataWidth-1:0] word);
    busWrite(methodAddr(1'b1, m, offMethodData), word);
    expectQ.push_back(word + dataWidth'(m));
  endtask

  task automatic popWord();
    logic [dataWidth-1:0] expected;
    expected = expectQ.pop_front();
    checkRead(methodAddr(1'b0, 2'd0, offMethodData), expected, "indication data");
  endtask

  task automatic stalledWrite(input portalAddrT addr, input logic [dataWidth-1:0] data);
    @(negedge CLK);
    wbCyc  = 1'b1;
    wbStb  = 1'b1;
    wbWe   = 1'b1;
    wbAdr  = addr;
    wbDatW = data;
    repeat (stallCycles) begin
      @(negedge CLK);
      assert (!wbAck) else begin
        $display("[ERROR] %0d ns: request write completed with the queue full", $time);
        errorCount++;
      end
    end
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe  = 1'b0;
  endtask

  // --------------------------------------------------------------------
  // Test sequence.
  // --------------------------------------------------------------------
  initial begin
    logic [dataWidth-1:0] word;
    methodT m;
    int count;
    RST_N  = 1'b0;
    wbCyc  = 1'b0;
    wbStb  = 1'b0;
    wbWe   = 1'b0;
    wbAdr  = '0;
    wbDatW = '0;
    repeat (resetCycles) @(negedge CLK);
    RST_N = 1'b1;

    for (int sel = 0; sel < 2; sel++) begin
      checkRead(ctrlAddr(sel[0], offVersion), versionWord, "version");
      checkRead(ctrlAddr(sel[0], offPortalId), sel[0] ? idRequest : idIndication, "portal id");
      checkRead(ctrlAddr(sel[0], offPortalCount), portalCount, "portal count");
      checkRead(ctrlAddr(sel[0], offReservedA), '0, "reserved A");
      checkRead(ctrlAddr(sel[0], offReservedB), '0, "reserved B");
      checkRead(ctrlAddr(sel[0], offIntrStatus), '0, "idle interrupt status");
    end
    checkRead(ctrlAddr(1'b0, 5'h02), unusedMarker, "unused offset");

    // FIFO order across mixed methods, with status words.
    pushWord(2'd1, takeBits(32));
    checkRead(methodAddr(1'b0, 2'd0, offMethodStatus), 32'd1, "indication status");
    checkRead(ctrlAddr(1'b0, offIntrStatus), 32'd1, "indication interrupt status");
    checkRead(ctrlAddr(1'b0, offChannelStatus), 32'd1, "indication channel status");
    checkRead(ctrlAddr(1'b1, offIntrStatus), 32'd0, "request interrupt status");
    pushWord(2'd3, takeBits(32));
    pushWord(2'd0, takeBits(32));
    repeat (3) popWord();
    checkRead(methodAddr(1'b0, 2'd0, offMethodStatus), 32'd0, "drained indication status");
    checkRead(ctrlAddr(1'b0, offIntrStatus), 32'd0, "drained interrupt status");
    checkRead(methodAddr(1'b1, 2'd0, offMethodStatus), 32'd1, "request status");
    checkRead(methodAddr(1'b0, 2'd1, 5'h08), 32'd0, "unused method word");

    // Interrupt enable and irq.
    pushWord(2'd2, takeBits(32));
    checkIrq(1'b0, "irq high before enable");
    checkRead(ctrlAddr(1'b0, offIntrEnable), 32'd0, "indication enable at reset");
    busWrite(ctrlAddr(1'b0, offIntrEnable), 32'd1);
    checkRead(ctrlAddr(1'b0, offIntrEnable), 32'd1, "indication enable set");
    checkIrq(1'b1, "irq low with enable set and word pending");
    busWrite(ctrlAddr(1'b0, offIntrEnable), 32'd0);
    checkRead(ctrlAddr(1'b0, offIntrEnable), 32'd0, "indication enable cleared");
    checkIrq(1'b0, "irq high after enable cleared");
    busWrite(ctrlAddr(1'b0, offIntrEnable), 32'd1);
    checkIrq(1'b1, "irq low after enable set again");
    popWord();
    checkIrq(1'b0, "irq high after queue drained");
    busWrite(ctrlAddr(1'b1, offIntrEnable), 32'd1);
    checkRead(ctrlAddr(1'b1, offIntrEnable), 32'd1, "request enable");
    busWrite(ctrlAddr(1'b0, offIntrEnable), 32'd0);

    // Back-pressure with a full queue.
    for (int i = 0; i < queueDepth; i++) begin
      pushWord(methodT'(i), takeBits(32));
    end
    checkRead(methodAddr(1'b1, 2'd0, offMethodStatus), 32'd0, "request status when full");
    word = takeBits(32);
    m = methodT'(takeBits(2));
    stalledWrite(methodAddr(1'b1, m, offMethodData), word);
    popWord();
    checkRead(methodAddr(1'b1, 2'd0, offMethodStatus), 32'd1, "request status after pop");
    pushWord(m, word);
    repeat (queueDepth) popWord();

    for (int r = 0; r < randomRounds; r++) begin
      count = 1 + int'(takeBits(2));
      repeat (count) pushWord(methodT'(takeBits(2)), takeBits(32));
      repeat (count) popWord();
    end
    checkRead(methodAddr(1'b0, 2'd0, offMethodStatus), 32'd0, "final indication status");

    $display("Errors: %0d read checks, %0d assertion failures",
             errorCount, dut_i.props_i.failCount);
    if (errorCount == 0 && dut_i.props_i.failCount == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// File: verilog/echoCore.sv
`timescale 1ns/1ps

module echoCore #(
  parameter int fifoDepth = portalPkg::fifoDepth
) (
  input  logic                            CLK,
  input  logic                            RST_N,
  input  logic                            reqValid,
  input  portalPkg::methodT               reqMethod,
  input  logic [portalPkg::dataWidth-1:0] reqData,
  output logic                            reqReady,
  input  logic                            indPop,
  output logic [portalPkg::dataWidth-1:0] indData,
  output logic                            indValid
);
  import portalPkg::*;

  logic [dataWidth-1:0] echoWord;
  logic                 queueFull;
  logic                 accept;

  // ----------------------------------------------------------------------
  // Request side.
  // ----------------------------------------------------------------------
  assign reqReady = !queueFull;
  assign accept   = reqValid && !queueFull;

  // Indication word is the request word plus its method number.
  assign echoWord = reqData + dataWidth'(reqMethod);

  // ----------------------------------------------------------------------
  // Indication queue.
  // ----------------------------------------------------------------------
  portalFifo #(
    .width (dataWidth),
    .depth (fifoDepth)
  ) indQueue_i (
    .CLK      (CLK),
    .RST_N    (RST_N),
    .push     (accept),
    .pushData (echoWord),
    .pop      (indPop),
    .popData  (indData),
    .full     (queueFull),
    .notEmpty (indValid)
  );

endmodule

// File: verilog/portalCtrlRegs.sv
`timescale 1ns/1ps

module portalCtrlRegs (
  input  logic                            CLK,
  input  logic                            RST_N,
  input  logic                            ctrlSel,
  input  logic [4:0]                      ctrlOffset,
  input  logic                            ctrlWrite,
  input  logic [portalPkg::dataWidth-1:0] ctrlWdata,
  output logic [portalPkg::dataWidth-1:0] ctrlRdata,
  input  logic                            indPending,
  output logic                            irq
);
  import portalPkg::*;

  logic                 indIntrEn;
  logic                 reqIntrEn;
  logic                 pending;
  logic [dataWidth-1:0] chanMask;

  // ----------------------------------------------------------------------
  // Interrupt enables, one per portal.
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      indIntrEn <= 1'b0;
      reqIntrEn <= 1'b0;
    end else if (ctrlWrite && ctrlOffset == offIntrEnable) begin
      if (ctrlSel) begin
        reqIntrEn <= ctrlWdata[0];
      end else begin
        indIntrEn <= ctrlWdata[0];
      end
    end
  end

  // Only the indication portal has an interrupt source.
  assign pending = ctrlSel ? 1'b0 : indPending;

  always_comb begin
    chanMask    = '0;
    chanMask[0] = pending;
  end

  assign irq = indPending && indIntrEn;

  // ----------------------------------------------------------------------
  // Control page read.
  // ----------------------------------------------------------------------
  always_comb begin
    case (ctrlOffset)
      offIntrStatus:    ctrlRdata = dataWidth'(chanMask != '0);
      offIntrEnable:    ctrlRdata = dataWidth'(ctrlSel ? reqIntrEn : indIntrEn);
      offVersion:       ctrlRdata = versionWord;
      offChannelStatus: ctrlRdata = chanMask;
      offPortalId:      ctrlRdata = ctrlSel ? idRequest : idIndication;
      offPortalCount:   ctrlRdata = portalCount;
      offReservedA:     ctrlRdata = '0;
      offReservedB:     ctrlRdata = '0;
      default:          ctrlRdata = unusedMarker;
    endcase
  end

endmodule

// File: verilog/portalFifo.sv
`timescale 1ns/1ps

module portalFifo #(
  parameter int width = portalPkg::dataWidth,
  parameter int depth = portalPkg::fifoDepth
) (
  input  logic             CLK,
  input  logic             RST_N,
  input  logic             push,
  input  logic [width-1:0] pushData,
  input  logic             pop,
  output logic [width-1:0] popData,
  output logic             full,
  output logic             notEmpty
);

  localparam int ptrWidth = (depth > 1) ? $clog2(depth) : 1;
  localparam int cntWidth = $clog2(depth + 1);

  logic [width-1:0]    mem [depth];
  logic [ptrWidth-1:0] rdPtr;
  logic [ptrWidth-1:0] wrPtr;
  logic [cntWidth-1:0] count;
  logic                doPush;
  logic                doPop;

  assign full     = (count == cntWidth'(depth));
  assign notEmpty = (count != '0);
  assign doPush   = push && !full;
  assign doPop    = pop && notEmpty;

  // Head of queue is always presented.
  assign popData = mem[rdPtr];

  always_ff @(posedge CLK) begin
    if (doPush) begin
      mem[wrPtr] <= pushData;
    end
  end

  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == ptrWidth'(depth - 1)) ? '0 : wrPtr + ptrWidth'(1);
      end
      if (doPop) begin
        rdPtr <= (rdPtr == ptrWidth'(depth - 1)) ? '0 : rdPtr + ptrWidth'(1);
      end
      // Simultaneous push and pop leaves the occupancy unchanged.
      case ({doPush, doPop})
        2'b10:   count <= count + cntWidth'(1);
        2'b01:   count <= count - cntWidth'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

// File: verilog/portalPkg.sv
package portalPkg;

  localparam int dataWidth = 32;
  localparam int addrWidth = 13;
  localparam int fifoDepth = 4;

  typedef logic [1:0] methodT;

  // ----------------------------------------------------------------------
  // Control page offsets.
  // ----------------------------------------------------------------------
  localparam logic [4:0] offIntrStatus    = 5'h00;
  localparam logic [4:0] offIntrEnable    = 5'h04;
  localparam logic [4:0] offVersion       = 5'h08;
  localparam logic [4:0] offChannelStatus = 5'h0C;
  localparam logic [4:0] offPortalId      = 5'h10;
  localparam logic [4:0] offPortalCount   = 5'h14;
  localparam logic [4:0] offReservedA     = 5'h18;
  localparam logic [4:0] offReservedB     = 5'h1C;

  // Method page offsets.
  localparam logic [4:0] offMethodData   = 5'h00;
  localparam logic [4:0] offMethodStatus = 5'h04;

  localparam logic [dataWidth-1:0] idIndication = 32'd5;
  localparam logic [dataWidth-1:0] idRequest    = 32'd6;
  localparam logic [dataWidth-1:0] portalCount  = 32'd2;
  localparam logic [dataWidth-1:0] versionWord  = 32'd1;
  localparam logic [dataWidth-1:0] unusedMarker = 32'h005A05A0;

  // One portal address, read as a control register or as a method word.
  typedef union packed {
    struct packed {
      logic                   portalSel;
      logic [addrWidth-7:0]   region;
      logic [4:0]             regOffset;
    } ctrlView;
    struct packed {
      logic                   portalSel;
      logic [addrWidth-9:0]   pad;
      methodT                 methodSel;
      logic [4:0]             wordOffset;
    } methodView;
  } portalAddrT;

endpackage

// File: verilog/portalTop.sv
`timescale 1ns/1ps

module portalTop #(
  parameter int fifoDepth = portalPkg::fifoDepth
) (
  input  logic                            CLK,
  input  logic                            RST_N,
  input  logic                            wbCyc,
  input  logic                            wbStb,
  input  logic                            wbWe,
  input  portalPkg::portalAddrT           wbAdr,
  input  logic [portalPkg::dataWidth-1:0] wbDatW,
  output logic [portalPkg::dataWidth-1:0] wbDatR,
  output logic                            wbAck,
  output logic                            irq
);
  import portalPkg::*;

  logic                 ctrlSel;
  logic [4:0]           ctrlOffset;
  logic                 ctrlWrite;
  logic [dataWidth-1:0] ctrlWdata;
  logic [dataWidth-1:0] ctrlRdata;
  logic                 reqValid;
  methodT               reqMethod;
  logic [dataWidth-1:0] reqData;
  logic                 reqReady;
  logic                 indPop;
  logic [dataWidth-1:0] indData;
  logic                 indValid;

  wbPortalBridge bridge_i (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .wbCyc      (wbCyc),
    .wbStb      (wbStb),
    .wbWe       (wbWe),
    .wbAdr      (wbAdr),
    .wbDatW     (wbDatW),
    .wbDatR     (wbDatR),
    .wbAck      (wbAck),
    .ctrlSel    (ctrlSel),
    .ctrlOffset (ctrlOffset),
    .ctrlWrite  (ctrlWrite),
    .ctrlWdata  (ctrlWdata),
    .ctrlRdata  (ctrlRdata),
    .reqValid   (reqValid),
    .reqMethod  (reqMethod),
    .reqData    (reqData),
    .reqReady   (reqReady),
    .indPop     (indPop),
    .indData    (indData),
    .indValid   (indValid)
  );

  portalCtrlRegs ctrlRegs_i (
    .CLK        (CLK),
    .RST_N      (RST_N),
    .ctrlSel    (ctrlSel),
    .ctrlOffset (ctrlOffset),
    .ctrlWrite  (ctrlWrite),
    .ctrlWdata  (ctrlWdata),
    .ctrlRdata  (ctrlRdata),
    .indPending (indValid),
    .irq        (irq)
  );

  echoCore #(
    .fifoDepth (fifoDepth)
  ) core_i (
    .CLK       (CLK),
    .RST_N     (RST_N),
    .reqValid  (reqValid),
    .reqMethod (reqMethod),
    .reqData   (reqData),
    .reqReady  (reqReady),
    .indPop    (indPop),
    .indData   (indData),
    .indValid  (indValid)
  );

endmodule

// File: verilog/wbPortalBridge.sv
`timescale 1ns/1ps

module wbPortalBridge (
  input  logic                            CLK,
  input  logic                            RST_N,
  input  logic                            wbCyc,
  input  logic                            wbStb,
  input  logic                            wbWe,
  input  portalPkg::portalAddrT           wbAdr,
  input  logic [portalPkg::dataWidth-1:0] wbDatW,
  output logic [portalPkg::dataWidth-1:0] wbDatR,
  output logic                            wbAck,
  output logic                            ctrlSel,
  output logic [4:0]                      ctrlOffset,
  output logic                            ctrlWrite,
  output logic [portalPkg::dataWidth-1:0] ctrlWdata,
  input  logic [portalPkg::dataWidth-1:0] ctrlRdata,
  output logic                            reqValid,
  output portalPkg::methodT               reqMethod,
  output logic [portalPkg::dataWidth-1:0] reqData,
  input  logic                            reqReady,
  output logic                            indPop,
  input  logic [portalPkg::dataWidth-1:0] indData,
  input  logic                            indValid
);
  import portalPkg::*;

  logic                 isCtrl;
  logic                 isReqPortal;
  logic                 isDataWord;
  logic                 isStatusWord;
  logic                 pushAcc;
  logic                 popAcc;
  logic                 canServe;
  logic                 fire;
  logic [dataWidth-1:0] rdWord;

  // ----------------------------------------------------------------------
  // Address decode.
  // ----------------------------------------------------------------------
  assign isCtrl       = (wbAdr.ctrlView.region == '0);
  assign isReqPortal  = wbAdr.ctrlView.portalSel;
  assign isDataWord   = (wbAdr.methodView.wordOffset == offMethodData);
  assign isStatusWord = (wbAdr.methodView.wordOffset == offMethodStatus);

  assign pushAcc = !isCtrl && isReqPortal && wbWe && isDataWord;
  assign popAcc  = !isCtrl && !isReqPortal && !wbWe && isDataWord;

  // Data accesses wait for room or for a queued word.
  assign canServe = pushAcc ? reqReady : (popAcc ? indValid : 1'b1);
  assign fire     = wbCyc && wbStb && !wbAck && canServe;

  // Side effects land on the edge that raises the ack.
  assign ctrlSel    = isReqPortal;
  assign ctrlOffset = wbAdr.ctrlView.regOffset;
  assign ctrlWdata  = wbDatW;
  assign ctrlWrite  = fire && isCtrl && wbWe;
  assign reqValid   = fire && pushAcc;
  assign reqMethod  = wbAdr.methodView.methodSel;
  assign reqData    = wbDatW;
  assign indPop     = fire && popAcc;

  always_comb begin
    if (isCtrl) begin
      rdWord = ctrlRdata;
    end else if (popAcc) begin
      rdWord = indData;
    end else if (isStatusWord) begin
      rdWord = dataWidth'(isReqPortal ? reqReady : indValid);
    end else begin
      rdWord = '0;
    end
  end

  // ----------------------------------------------------------------------
  // Registered ack and read data.
  // ----------------------------------------------------------------------
  always_ff @(posedge CLK) begin
    if (!RST_N) begin
      wbAck <= 1'b0;
    end else begin
      wbAck <= fire;
    end
  end

  always_ff @(posedge CLK) begin
    if (fire) begin
      wbDatR <= rdWord;
    end
  end

endmodule

// File: vlog.f
verilog/portalPkg.sv
verilog/portalFifo.sv
verilog/echoCore.sv
verilog/portalCtrlRegs.sv
verilog/wbPortalBridge.sv
verilog/portalTop.sv
sim/portalProperties.sv
sim/portalTb.sv
